/* flist.f */
common/sam_pkg.sv
common/video_mem_if.sv
video/video_timing.sv
video/pixel_engine.sv
source/io_ports.sv
source/mem_mapper.sv
source/sam_asic.sv
dv/tb_sam_asic.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_sam_asic \
    -f flist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_sam_asic > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi
exit 0

/* dv/tb_sam_asic.sv */
`timescale 1ns/1ps

module tb_sam_asic
    import sam_pkg::*;
();

    typedef enum int {IO_WR, IO_RD, MEM_RD, MEM_WR} kind_e;
    typedef enum int {CHK_ADDR = 1, CHK_WR = 2, CHK_ROM = 4, CHK_DATA = 8, CHK_NOWAIT = 16} chk_e;

    typedef struct {
        int          test;
        kind_e       kind;
        logic [15:0] addr;
        logic [7:0]  data;
        int          chk;
        logic [18:0] exp_addr;
        logic        exp_wr;
        logic        exp_rom;
        logic [7:0]  exp_data;
    } row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        mreq_n;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic [15:0] cpuaddr;
    logic [7:0]  data_from_cpu;
    logic [7:0]  data_to_cpu;
    logic        wait_n;
    logic [18:0] ramaddr;
    logic [7:0]  data_from_ram;
    logic [7:0]  data_to_ram;
    logic        ramwr_n;
    logic        romcs_n;
    logic        mic;
    logic        beep;
    logic [1:0]  r;
    logic [1:0]  g;
    logic [1:0]  b;
    logic        bright;
    logic        csync;
    logic        int_n;

    row_t        rows[$];
    int          seed = 4;
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_tests = 0;
    int          test_checks0;
    int          test_errors0;
    logic [7:0]  ram_byte;
    logic [7:0]  border_rnd;
    logic [6:0]  clut_rnd;

    sam_asic UUT (.*);

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Checking and reporting
    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_fail(input string msg);
        n_errors++;
        $display("** Failure at %0t ns: %s", $time, msg);
    endtask

    task automatic start_test();
        test_checks0 = n_checks;
        test_errors0 = n_errors;
    endtask

    task automatic end_test(input string name);
        n_tests++;
        $display("test %-24s %0d checks, %0d errors", name, n_checks - test_checks0,
                 n_errors - test_errors0);
    endtask

    ////////////////////////////////////////////////////////////
    // Bus cycles
    task automatic bus_access(input kind_e kind, input logic [15:0] addr, input logic [7:0] data,
                              input int hold, output bit saw_wait, output bit done);
        int n;
        @(negedge clk);
        cpuaddr       = addr;
        data_from_cpu = data;
        mreq_n        = !(kind == MEM_RD || kind == MEM_WR);
        iorq_n        = !(kind == IO_RD || kind == IO_WR);
        rd_n          = !(kind == MEM_RD || kind == IO_RD);
        wr_n          = !(kind == MEM_WR || kind == IO_WR);
        n        = 0;
        saw_wait = 0;
        done     = 0;
        #1;
        // CPU keeps its strobes while stalled
        while (!done && n < 64) begin
            if (!wait_n)
                saw_wait = 1;
            if (n >= hold && wait_n) begin
                done = 1;
            end else begin
                @(negedge clk);
                #1;
                n++;
            end
        end
        if (!done)
            report_fail($sformatf("wait_n stayed low on a bus access at %h", addr));
    endtask

    task automatic bus_release();
        @(negedge clk);
        mreq_n        = 1'b1;
        iorq_n        = 1'b1;
        rd_n          = 1'b1;
        wr_n          = 1'b1;
        data_from_cpu = 8'h00;
    endtask

    task automatic apply_row(input row_t row);
        bit saw;
        bit done;
        bus_access(row.kind, row.addr, row.data, (row.chk & CHK_NOWAIT) ? 16 : 0, saw, done);
        if (done) begin
            if (row.chk & CHK_ADDR)
                check_val("ramaddr", ramaddr, row.exp_addr);
            if (row.chk & CHK_WR)
                check_val("ramwr_n", ramwr_n, row.exp_wr);
            if (row.chk & CHK_ROM)
                check_val("romcs_n", romcs_n, row.exp_rom);
            if ((row.chk & CHK_DATA) && row.kind == MEM_WR)
                check_val("data_to_ram", data_to_ram, row.exp_data);
            else if (row.chk & CHK_DATA)
                check_val("data_to_cpu", data_to_cpu, row.exp_data);
            if (row.chk & CHK_NOWAIT)
                check_val("wait_n low seen", saw, 0);
        end
        bus_release();
    endtask

    task automatic run_rows(input int test);
        for (int i = 0; i < rows.size(); i++)
            if (rows[i].test == test)
                apply_row(rows[i]);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    task automatic add_row(input int test, input kind_e kind, input logic [15:0] addr,
                           input logic [7:0] data, input int chk, input logic [18:0] exp_addr,
                           input logic exp_wr, input logic exp_rom, input logic [7:0] exp_data);
        row_t row;
        row.test     = test;
        row.kind     = kind;
        row.addr     = addr;
        row.data     = data;
        row.chk      = chk;
        row.exp_addr = exp_addr;
        row.exp_wr   = exp_wr;
        row.exp_rom  = exp_rom;
        row.exp_data = exp_data;
        rows.push_back(row);
    endtask

    task automatic io_row(input int test, input logic [15:0] addr, input logic [7:0] data);
        add_row(test, IO_WR, addr, data, 0, '0, 1'b1, 1'b1, 8'h00);
    endtask

    task automatic build_table();
        logic [7:0]  r_l;
        logic [7:0]  r_h;
        logic [7:0]  r_v;
        logic [7:0]  wd [5];
        logic [4:0]  lp;
        logic [4:0]  hp;
        logic [13:0] ofs [7];
        int          mem_chk;
        r_l        = $random(seed);
        r_h        = $random(seed);
        r_v        = $random(seed);
        border_rnd = $random(seed);
        clut_rnd   = $random(seed);
        lp         = $random(seed);
        hp         = $random(seed);
        for (int i = 0; i < 5; i++)
            wd[i] = $random(seed);
        for (int i = 0; i < 7; i++)
            ofs[i] = $random(seed);
        mem_chk = CHK_ADDR | CHK_WR | CHK_ROM | CHK_DATA;

        // ROM select, LMPR bit 6 brings ROM into section D
        add_row(0, MEM_RD, 16'h1234, 8'h00, CHK_ROM | CHK_NOWAIT, '0, 1'b1, 1'b0, 8'h00);
        add_row(0, MEM_RD, 16'h3FFF, 8'h00, CHK_ROM | CHK_NOWAIT, '0, 1'b1, 1'b0, 8'h00);
        add_row(0, MEM_WR, 16'h0100, 8'h5A, CHK_WR | CHK_ROM | CHK_NOWAIT, '0, 1'b1, 1'b0, 8'h00);
        io_row(0, {8'h00, PORT_LMPR}, 8'h40);
        add_row(0, MEM_RD, 16'hC000, 8'h00, CHK_ROM | CHK_NOWAIT, '0, 1'b1, 1'b0, 8'h00);
        add_row(0, MEM_RD, 16'hFFFF, 8'h00, CHK_ROM | CHK_NOWAIT, '0, 1'b1, 1'b0, 8'h00);
        add_row(0, MEM_RD, 16'h8123, 8'h00, CHK_ADDR | CHK_ROM | CHK_DATA, 19'h00123,
                1'b1, 1'b1, ram_byte);

        // Register read-back
        io_row(1, {8'h00, PORT_LMPR}, r_l);
        io_row(1, {8'h00, PORT_HMPR}, r_h);
        io_row(1, {8'h00, PORT_VMPR}, r_v);
        add_row(1, IO_RD, {8'h00, PORT_LMPR}, 8'h00, CHK_DATA, '0, 1'b1, 1'b1, r_l);
        add_row(1, IO_RD, {8'h00, PORT_HMPR}, 8'h00, CHK_DATA, '0, 1'b1, 1'b1, r_h);
        add_row(1, IO_RD, {8'h00, PORT_VMPR}, 8'h00, CHK_DATA, '0, 1'b1, 1'b1, r_v);
        io_row(1, {8'h00, PORT_BORDER}, border_rnd);

        // Paging with the display off, ROM out of section A
        io_row(2, {8'h00, PORT_BORDER}, 8'h80);
        io_row(2, {8'h00, PORT_LMPR}, {3'b001, lp});
        io_row(2, {8'h00, PORT_HMPR}, {3'b000, hp});
        add_row(2, MEM_RD, {2'b01, ofs[0]}, 8'h00, CHK_ADDR | CHK_ROM | CHK_DATA,
                {lp, ofs[0]}, 1'b1, 1'b1, ram_byte);
        add_row(2, MEM_WR, {2'b01, ofs[1]}, wd[0], mem_chk, {lp, ofs[1]}, 1'b0, 1'b1, wd[0]);
        add_row(2, MEM_RD, {2'b10, ofs[2]}, 8'h00, CHK_ADDR | CHK_ROM | CHK_DATA,
                {hp, ofs[2]}, 1'b1, 1'b1, ram_byte);
        add_row(2, MEM_WR, {2'b11, ofs[3]}, wd[1], mem_chk, {hp, ofs[3]}, 1'b0, 1'b1, wd[1]);
        add_row(2, MEM_WR, {2'b00, ofs[4]}, wd[2], CHK_WR | CHK_ROM | CHK_DATA, '0,
                1'b0, 1'b1, wd[2]);
        // Write protect on section A only
        io_row(2, {8'h00, PORT_LMPR}, {3'b101, lp});
        add_row(2, MEM_WR, {2'b00, ofs[5]}, wd[3], CHK_WR | CHK_ROM | CHK_DATA, '0,
                1'b1, 1'b1, 8'h00);
        add_row(2, MEM_WR, {2'b01, ofs[6]}, wd[4], mem_chk, {lp, ofs[6]}, 1'b0, 1'b1, wd[4]);

        io_row(3, {8'h00, PORT_LINEINT}, 8'd10);

        io_row(4, {8'h00, PORT_LINEINT}, 8'hFF);
        io_row(4, {8'h05, PORT_CLUT}, {1'b0, clut_rnd});
        io_row(4, {8'h00, PORT_BORDER}, 8'h05);
        io_row(4, {8'h00, PORT_VMPR}, 8'h00);
    endtask

    ////////////////////////////////////////////////////////////
    // Raster monitors
    // Counts clocks while int_n (sel 0) or csync (sel 1) stays at lvl
    task automatic count_run(input int sel, input logic lvl, input int limit, output int n);
        logic v;
        n = 0;
        v = (sel == 0) ? int_n : csync;
        while (v == lvl && n < limit) begin
            @(negedge clk);
            n++;
            v = (sel == 0) ? int_n : csync;
        end
        if (n >= limit)
            report_fail($sformatf("%s stayed at %0d for %0d clocks",
                                  (sel == 0) ? "int_n" : "csync", lvl, limit));
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    task automatic test_rom();
        start_test();
        check_val("csync", csync, 1);
        check_val("int_n", int_n, 1);
        check_val("ramwr_n", ramwr_n, 1);
        check_val("wait_n", wait_n, 1);
        run_rows(0);
        end_test("rom select");
    endtask

    task automatic test_readback();
        start_test();
        run_rows(1);
        check_val("mic", mic, border_rnd[3]);
        check_val("beep", beep, border_rnd[4]);
        end_test("io read-back");
    endtask

    task automatic test_paging();
        start_test();
        run_rows(2);
        end_test("paging and protection");
    endtask

    task automatic test_sync();
        int skip;
        int lo;
        int hi;
        start_test();
        count_run(0, 1'b0, 1000, skip);
        count_run(0, 1'b1, 240000, skip);
        count_run(0, 1'b0, 1000, lo);
        count_run(0, 1'b1, 240000, hi);
        check_val("int_n low clocks", lo, INT_LEN);
        check_val("int_n period", lo + hi, V_TOTAL * H_TOTAL);
        // Well clear of the vertical sync span
        repeat (25 * H_TOTAL) @(negedge clk);
        count_run(1, 1'b0, 1000, skip);
        count_run(1, 1'b1, 1000, skip);
        count_run(1, 1'b0, 1000, lo);
        count_run(1, 1'b1, 1000, hi);
        check_val("csync low clocks", lo, H_SYNC);
        check_val("csync period", lo + hi, H_TOTAL);
        end_test("sync and frame interrupt");
    endtask

    task automatic test_raster();
        int skip;
        int lo1;
        int hi1;
        int lo2;
        int hi2;
        int gap;
        start_test();
        run_rows(3);
        count_run(0, 1'b0, 1000, skip);
        count_run(0, 1'b1, 240000, skip);
        count_run(0, 1'b0, 1000, lo1);
        count_run(0, 1'b1, 240000, hi1);
        count_run(0, 1'b0, 1000, lo2);
        count_run(0, 1'b1, 240000, hi2);
        // Frame to raster pulse is the shorter of the two spacings
        gap = (lo1 + hi1 < lo2 + hi2) ? lo1 + hi1 : lo2 + hi2;
        check_val("int_n first low clocks", lo1, INT_LEN);
        check_val("int_n second low clocks", lo2, INT_LEN);
        check_val("int_n period", lo1 + hi1 + lo2 + hi2, V_TOTAL * H_TOTAL);
        check_val("int_n frame to raster", gap,
                  (10 - 1 - VINT_LINE + V_TOTAL) * H_TOTAL + LINT_START - HINT_START);
        end_test("raster interrupt");
    endtask

    task automatic test_border();
        int skip;
        bit saw;
        bit done;
        start_test();
        run_rows(4);
        count_run(0, 1'b0, 1000, skip);
        count_run(0, 1'b1, 240000, skip);
        // Frame pulse start to line 200, pixel 256
        repeat ((V_TOTAL - VINT_LINE + 200) * H_TOTAL + 256 - HINT_START) @(negedge clk);
        check_val("r g b bright", {r, g, b, bright},
                  {clut_rnd[5], clut_rnd[1], clut_rnd[6], clut_rnd[2],
                   clut_rnd[4], clut_rnd[0], clut_rnd[3]});
        bus_access(MEM_RD, 16'h8000, 8'h00, 16, saw, done);
        check_val("wait_n low seen", saw, 1);
        check_val("data_to_cpu", data_to_cpu, ram_byte);
        bus_release();
        end_test("border and contention");
    endtask

    initial begin
        rst_n         = 1'b0;
        mreq_n        = 1'b1;
        iorq_n        = 1'b1;
        rd_n          = 1'b1;
        wr_n          = 1'b1;
        cpuaddr       = 16'h0000;
        data_from_cpu = 8'h00;
        ram_byte      = $random(seed);
        data_from_ram = ram_byte;
        build_table();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        test_rom();
        test_readback();
        test_paging();
        test_sync();
        test_raster();
        test_border();

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* source/sam_asic.sv */
`timescale 1ns/1ps

module sam_asic
    import sam_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // CPU bus
    input  logic        mreq_n,
    input  logic        iorq_n,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic [15:0] cpuaddr,
    input  logic [7:0]  data_from_cpu,
    output logic [7:0]  data_to_cpu,
    output logic        wait_n,
    // RAM and ROM
    output logic [18:0] ramaddr,
    input  logic [7:0]  data_from_ram,
    output logic [7:0]  data_to_ram,
    output logic        ramwr_n,
    output logic        romcs_n,
    // Audio and video
    output logic        mic,
    output logic        beep,
    output logic [1:0]  r,
    output logic [1:0]  g,
    output logic [1:0]  b,
    output logic        bright,
    output logic        csync,
    output logic        int_n
);

    logic [HC_W-1:0] hc;
    logic [VC_W-1:0] vc;
    video_cfg_t      video_cfg;
    page_cfg_t       page_cfg;
    logic [3:0]      clut_index;
    pix_colour_t     clut_colour;
    logic [7:0]      io_rdata;
    logic            io_rd_active;

    video_mem_if vmem ();

    video_timing u_timing (
        .clk       (clk),
        .rst_n     (rst_n),
        .video_cfg (video_cfg),
        .hc        (hc),
        .vc        (vc),
        .fetching  (vmem.fetching),
        .csync     (csync),
        .int_n     (int_n)
    );

    pixel_engine u_pixel (
        .clk         (clk),
        .rst_n       (rst_n),
        .hc          (hc),
        .vc          (vc),
        .video_cfg   (video_cfg),
        .vmem        (vmem.fetch),
        .clut_index  (clut_index),
        .clut_colour (clut_colour),
        .r           (r),
        .g           (g),
        .b           (b),
        .bright      (bright)
    );

    io_ports u_io (
        .clk           (clk),
        .rst_n         (rst_n),
        .iorq_n        (iorq_n),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .cpuaddr       (cpuaddr),
        .data_from_cpu (data_from_cpu),
        .video_cfg     (video_cfg),
        .page_cfg      (page_cfg),
        .mic           (mic),
        .beep          (beep),
        .clut_index    (clut_index),
        .clut_colour   (clut_colour),
        .io_rdata      (io_rdata),
        .io_rd_active  (io_rd_active)
    );

    mem_mapper u_mapper (
        .hc            (hc),
        .page_cfg      (page_cfg),
        .video_cfg     (video_cfg),
        .vmem          (vmem.mapper),
        .mreq_n        (mreq_n),
        .iorq_n        (iorq_n),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .cpuaddr       (cpuaddr),
        .data_from_cpu (data_from_cpu),
        .data_from_ram (data_from_ram),
        .io_rdata      (io_rdata),
        .io_rd_active  (io_rd_active),
        .ramaddr       (ramaddr),
        .data_to_ram   (data_to_ram),
        .data_to_cpu   (data_to_cpu),
        .ramwr_n       (ramwr_n),
        .romcs_n       (romcs_n),
        .wait_n        (wait_n)
    );

endmodule

/* source/mem_mapper.sv */
`timescale 1ns/1ps

module mem_mapper
    import sam_pkg::*;
(
    input  logic [HC_W-1:0] hc,
    input  page_cfg_t       page_cfg,
    input  video_cfg_t      video_cfg,
    video_mem_if.mapper     vmem,
    input  logic            mreq_n,
    input  logic            iorq_n,
    input  logic            rd_n,
    input  logic            wr_n,
    input  logic [15:0]     cpuaddr,
    input  logic [7:0]      data_from_cpu,
    input  logic [7:0]      data_from_ram,
    input  logic [7:0]      io_rdata,
    input  logic            io_rd_active,
    output logic [18:0]     ramaddr,
    output logic [7:0]      data_to_ram,
    output logic [7:0]      data_to_cpu,
    output logic            ramwr_n,
    output logic            romcs_n,
    output logic            wait_n
);

    logic rom_sel;
    logic owned;
    logic protect;
    logic cpu_access;

    ////////////////////////////////////////////////////////////
    // Contention
    // Display slots while fetching, refresh slots elsewhere,
    // and Spectrum style stalls across the line in mode 1
    always_comb begin
        vmem.contention = 1'b0;
        if (vmem.fetching && hc[3:0] < 4'd10)
            vmem.contention = 1'b1;
        else if (!vmem.fetching && hc[2:1] == 2'b00)
            vmem.contention = 1'b1;
        if (video_cfg.screen_mode == 2'd0 && hc[3:0] < 4'd10 && hc[9:4] < 6'd40)
            vmem.contention = 1'b1;
    end

    assign vmem.vdata = data_from_ram;

    assign rom_sel = (cpuaddr < 16'h4000 && page_cfg.rom_a)
                  || (cpuaddr >= 16'hC000 && page_cfg.rom_d);
    assign owned   = vmem.fetching && vmem.contention;
    assign protect = cpuaddr < 16'h4000 && page_cfg.wprot_a;

    assign cpu_access = !mreq_n || (!iorq_n && (!rd_n || !wr_n));

    // ROM accesses never wait
    assign wait_n  = !(vmem.contention && !rom_sel && cpu_access);
    assign romcs_n = !rom_sel;

    always_comb begin
        if (rom_sel || owned)
            ramaddr = vmem.vaddr;
        else if (cpuaddr[15])
            ramaddr = {page_cfg.high_page, cpuaddr[13:0]};
        else
            ramaddr = {page_cfg.low_page, cpuaddr[13:0]};
    end

    assign ramwr_n     = (rom_sel || owned || protect) ? 1'b1 : (mreq_n | wr_n);
    assign data_to_ram = ramwr_n ? 8'h00 : data_from_cpu;

    always_comb begin
        if (io_rd_active)
            data_to_cpu = io_rdata;
        else if (!mreq_n && !rd_n && (rom_sel || !owned))
            data_to_cpu = data_from_ram;
        else
            data_to_cpu = 8'h00;
    end

    a_no_rom_write : assert property (@(hc) ramwr_n || romcs_n);

endmodule

/* source/io_ports.sv */
`timescale 1ns/1ps

module io_ports
    import sam_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        iorq_n,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic [15:0] cpuaddr,
    input  logic [7:0]  data_from_cpu,
    output video_cfg_t  video_cfg,
    output page_cfg_t   page_cfg,
    output logic        mic,
    output logic        beep,
    input  logic [3:0]  clut_index,
    output pix_colour_t clut_colour,
    output logic [7:0]  io_rdata,
    output logic        io_rd_active
);

    logic [7:0]  vmpr;
    logic [7:0]  hmpr;
    logic [7:0]  lmpr;
    logic [7:0]  border;
    logic [7:0]  lineint;
    pix_colour_t clut [16];
    logic        io_wr;
    logic        io_rd;

    assign io_wr = !iorq_n && !wr_n;
    assign io_rd = !iorq_n && !rd_n;

    ////////////////////////////////////////////////////////////
    // Port writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vmpr    <= '0;
            hmpr    <= '0;
            lmpr    <= '0;
            border  <= '0;
            lineint <= 8'hFF;
            for (int i = 0; i < 16; i++)
                clut[i] <= '0;
        end else if (io_wr) begin
            case (cpuaddr[7:0])
                PORT_CLUT:    clut[cpuaddr[11:8]] <= data_from_cpu[6:0];
                PORT_LINEINT: lineint <= data_from_cpu;
                PORT_LMPR:    lmpr    <= data_from_cpu;
                PORT_HMPR:    hmpr    <= data_from_cpu;
                PORT_VMPR:    vmpr    <= data_from_cpu;
                PORT_BORDER:  border  <= data_from_cpu;
                default:      ;
            endcase
        end
    end

    // Only the paging registers read back
    always_comb begin
        io_rdata     = '0;
        io_rd_active = 1'b0;
        if (io_rd) begin
            case (cpuaddr[7:0])
                PORT_LMPR: begin io_rdata = lmpr; io_rd_active = 1'b1; end
                PORT_HMPR: begin io_rdata = hmpr; io_rd_active = 1'b1; end
                PORT_VMPR: begin io_rdata = vmpr; io_rd_active = 1'b1; end
                default:   ;
            endcase
        end
    end

    assign clut_colour = clut[clut_index];

    assign video_cfg.screen_mode   = vmpr[6:5];
    assign video_cfg.screen_page   = vmpr[4:0];
    assign video_cfg.clut_m3_hi    = hmpr[6:5];
    assign video_cfg.border_colour = {border[5], border[2:0]};
    assign video_cfg.screen_off    = border[7];
    assign video_cfg.lineint       = lineint;

    assign page_cfg.low_page  = lmpr[4:0];
    assign page_cfg.high_page = hmpr[4:0];
    assign page_cfg.rom_a     = !lmpr[5];
    assign page_cfg.rom_d     = lmpr[6];
    assign page_cfg.wprot_a   = lmpr[7];

    assign mic  = border[3];
    assign beep = border[4];

endmodule

/* video/pixel_engine.sv */
`timescale 1ns/1ps

module pixel_engine
    import sam_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [HC_W-1:0]   hc,
    input  logic [VC_W-1:0]   vc,
    input  video_cfg_t        video_cfg,
    video_mem_if.fetch        vmem,
    output logic [3:0]        clut_index,
    input  pix_colour_t       clut_colour,
    output logic [1:0]        r,
    output logic [1:0]        g,
    output logic [1:0]        b,
    output logic              bright
);

    logic [3:0]  slot;
    logic [14:0] screen_offs;
    logic [4:0]  screen_column;
    logic [4:0]  flash_cnt;
    logic [7:0]  vbyte [4];
    logic [18:0] next_addr;
    logic [7:0]  sreg_m12;
    logic [7:0]  attr_reg;
    logic [31:0] sreg_m3;
    logic [31:0] sreg_m4;
    logic [1:0]  m3_hi;
    logic        ink;

    assign slot = hc[3:0];

    ////////////////////////////////////////////////////////////
    // Screen address for the current mode
    always_comb begin
        case (video_cfg.screen_mode)
            2'd0: begin
                // Spectrum layout, attributes at 1800h
                if (slot[2])
                    next_addr = {video_cfg.screen_page, 4'b0110, vc[7:3], screen_column};
                else
                    next_addr = {video_cfg.screen_page, 1'b0, vc[7:6], vc[2:0], vc[5:3],
                                 screen_column};
            end
            2'd1:
                next_addr = {video_cfg.screen_page, slot[2], screen_offs[12:0]};
            default:
                next_addr = {video_cfg.screen_page[4:1], screen_offs};
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Fetch, load and shift
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            screen_offs   <= '0;
            screen_column <= '0;
            flash_cnt     <= '0;
            vmem.vaddr    <= '0;
            for (int i = 0; i < 4; i++)
                vbyte[i] <= '0;
            sreg_m12      <= '0;
            attr_reg      <= '0;
            sreg_m3       <= '0;
            sreg_m4       <= '0;
            m3_hi         <= '0;
        end else begin
            if (vc == VC_W'(V_TOTAL - 1) && hc == HC_W'(H_TOTAL - 1)) begin
                screen_offs   <= '0;
                screen_column <= '0;
                flash_cnt     <= flash_cnt + 1'b1;
            end

            // Even phases drive the address, odd phases capture
            if (vmem.fetching && !slot[3]) begin
                if (!slot[0]) begin
                    vmem.vaddr <= next_addr;
                end else begin
                    vbyte[slot[2:1]] <= vmem.vdata;
                    if (video_cfg.screen_mode[1] || slot[2:1] == 2'd3)
                        screen_offs <= screen_offs + 1'b1;
                    if (slot[2:1] == 2'd3)
                        screen_column <= screen_column + 1'b1;
                end
            end

            if (slot == 4'd9) begin
                if (vmem.fetching) begin
                    sreg_m12 <= vbyte[0];
                    attr_reg <= vbyte[2];
                    sreg_m3  <= {vbyte[0], vbyte[1], vbyte[2], vbyte[3]};
                    sreg_m4  <= {vbyte[0], vbyte[1], vbyte[2], vbyte[3]};
                    m3_hi    <= video_cfg.clut_m3_hi;
                end else begin
                    // Border as paper, or as a solid pattern
                    sreg_m12 <= '0;
                    attr_reg <= {1'b0, video_cfg.border_colour, 3'b000};
                    sreg_m3  <= {16{video_cfg.border_colour[1:0]}};
                    sreg_m4  <= {8{video_cfg.border_colour}};
                    m3_hi    <= video_cfg.border_colour[3:2];
                end
            end else begin
                if (hc[0]) begin
                    sreg_m12 <= {sreg_m12[6:0], 1'b0};
                    sreg_m4  <= {sreg_m4[27:0], 4'h0};
                end
                sreg_m3 <= {sreg_m3[29:0], 2'b00};
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Colour selection
    assign ink = sreg_m12[7] ^ (attr_reg[7] & flash_cnt[4]);

    always_comb begin
        case (video_cfg.screen_mode)
            2'd0, 2'd1:
                clut_index = ink ? {attr_reg[6], attr_reg[2:0]} : {attr_reg[6], attr_reg[5:3]};
            2'd2:
                clut_index = {m3_hi, sreg_m3[31:30]};
            default:
                clut_index = sreg_m4[31:28];
        endcase
    end

    assign r      = {clut_colour[5], clut_colour[1]};
    assign g      = {clut_colour[6], clut_colour[2]};
    assign b      = {clut_colour[4], clut_colour[0]};
    assign bright = clut_colour[3];

    a_vaddr_in_window : assert property (@(posedge clk) disable iff (!rst_n)
        $changed(vmem.vaddr) |-> $past(vmem.fetching));

endmodule

/* video/video_timing.sv */
`timescale 1ns/1ps

module video_timing
    import sam_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  video_cfg_t      video_cfg,
    output logic [HC_W-1:0] hc,
    output logic [VC_W-1:0] vc,
    output logic            fetching,
    output logic            csync,
    output logic            int_n
);

    logic            hsync_n;
    logic            vsync_span;
    logic            vint;
    logic            rint;
    logic [VC_W-1:0] lint_prev;

    ////////////////////////////////////////////////////////////
    // Raster counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hc <= '0;
            vc <= '0;
        end else if (hc == HC_W'(H_TOTAL - 1)) begin
            hc <= '0;
            if (vc == VC_W'(V_TOTAL - 1))
                vc <= '0;
            else
                vc <= vc + 1'b1;
        end else begin
            hc <= hc + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Composite sync
    assign hsync_n = !(hc >= HC_W'(HINT_START) && hc < HC_W'(HSYNC_END));

    // Four lines, starting and ending at the left border
    assign vsync_span = (vc > VC_W'(VINT_LINE) && vc < VC_W'(VINT_LINE + V_SYNC))
                     || (vc == VC_W'(VINT_LINE) && hc >= HC_W'(VSYNC_HPOS))
                     || (vc == VC_W'(VINT_LINE + V_SYNC) && hc < HC_W'(VSYNC_HPOS));

    assign csync = hsync_n ^ vsync_span;

    ////////////////////////////////////////////////////////////
    // Frame and raster line interrupts
    assign vint = (vc == VC_W'(VINT_LINE) && hc >= HC_W'(HINT_START))
               || (vc == VC_W'(VINT_LINE + 1) && hc < HC_W'(HINT_END));

    // Line 0 is announced at the end of the last line
    assign lint_prev = (video_cfg.lineint == 8'd0) ? VC_W'(V_TOTAL - 1)
                                                   : VC_W'(video_cfg.lineint) - 1'b1;

    assign rint = (video_cfg.lineint < 8'd192)
               && ((vc == lint_prev && hc >= HC_W'(LINT_START))
                || (vc == VC_W'(video_cfg.lineint) && hc < HC_W'(LINT_END)));

    assign int_n = !(vint || rint);

    assign fetching = (vc < VC_W'(V_ACTIVE)) && (hc < HC_W'(H_ACTIVE)) && !video_cfg.screen_off;

    a_hc_range : assert property (@(posedge clk) disable iff (!rst_n)
        hc <= HC_W'(H_TOTAL - 1));

endmodule

/* common/video_mem_if.sv */
`timescale 1ns/1ps

interface video_mem_if;

    logic [18:0] vaddr;
    logic [7:0]  vdata;
    logic        fetching;
    logic        contention;

    // Pixel fetcher side
    modport fetch (
        output vaddr,
        input  vdata,
        input  fetching,
        input  contention
    );

    // Memory mapper side
    modport mapper (
        input  vaddr,
        output vdata,
        input  fetching,
        output contention
    );

endinterface

/* common/sam_pkg.sv */
package sam_pkg;

    ////////////////////////////////////////////////////////////
    // Raster timing, pixel clocks and lines
    localparam int H_ACTIVE  = 512;
    localparam int H_RBORDER = 64;
    localparam int H_FPORCH  = 16;
    localparam int H_SYNC    = 64;
    localparam int H_BPORCH  = 64;
    localparam int H_LBORDER = 48;
    localparam int H_TOTAL   = H_ACTIVE + H_RBORDER + H_FPORCH + H_SYNC + H_BPORCH + H_LBORDER;

    localparam int V_ACTIVE  = 192;
    localparam int V_BBORDER = 48;
    localparam int V_FPORCH  = 4;
    localparam int V_SYNC    = 4;
    localparam int V_BPORCH  = 16;
    localparam int V_TBORDER = 48;
    localparam int V_TOTAL   = V_ACTIVE + V_BBORDER + V_FPORCH + V_SYNC + V_BPORCH + V_TBORDER;

    // Derived positions
    localparam int VINT_LINE  = V_ACTIVE + V_BBORDER + V_FPORCH - 1;
    localparam int HINT_START = H_ACTIVE + H_RBORDER + H_FPORCH;
    localparam int HSYNC_END  = HINT_START + H_SYNC;
    localparam int VSYNC_HPOS = HSYNC_END + H_BPORCH;
    localparam int LINT_START = 704;
    localparam int INT_LEN    = 256;
    // Both pulses run into the next line
    localparam int HINT_END   = HINT_START + INT_LEN - H_TOTAL;
    localparam int LINT_END   = LINT_START + INT_LEN - H_TOTAL;

    localparam int HC_W = 10;
    localparam int VC_W = 9;

    ////////////////////////////////////////////////////////////
    // I/O port numbers, low address byte
    localparam logic [7:0] PORT_CLUT    = 8'd248;
    localparam logic [7:0] PORT_LINEINT = 8'd249;
    localparam logic [7:0] PORT_LMPR    = 8'd250;
    localparam logic [7:0] PORT_HMPR    = 8'd251;
    localparam logic [7:0] PORT_VMPR    = 8'd252;
    localparam logic [7:0] PORT_BORDER  = 8'd254;

    // G1 R1 B1 BRIGHT G0 R0 B0
    typedef logic [6:0] pix_colour_t;

    typedef struct packed {
        logic [1:0] screen_mode;
        logic [4:0] screen_page;
        logic [1:0] clut_m3_hi;
        logic [3:0] border_colour;
        logic       screen_off;
        logic [7:0] lineint;
    } video_cfg_t;

    typedef struct packed {
        logic [4:0] low_page;
        logic [4:0] high_page;
        logic       rom_a;
        logic       rom_d;
        logic       wprot_a;
    } page_cfg_t;

endpackage
